//--- common/periph_xbar_pkg.sv
package periph_xbar_pkg;

  // Bus field types shared by every stage of the peripheral crossbar
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  // Atomic opcode, carried through to the peripheral untouched
  typedef logic [5:0]  atop_t;

  // Address bits 31..24 that identify this cluster
  localparam logic [7:0] CLUSTER_BASE = 8'h10;

  // Peripheral window in address bits 23..20, bounds inclusive
  localparam logic [3:0] PERIPH_WIN_LO = 4'h2;
  localparam logic [3:0] PERIPH_WIN_HI = 4'h3;

  // Port select field starts here and is log2(NB_SLAVES) bits wide
  localparam int ROUTING_LSB = 16;

  // True when the address targets a peripheral of this cluster
  // Anything else belongs to the external port
  function automatic logic in_periph_window(addr_t addr);
    logic cluster_hit;
    logic window_hit;
    cluster_hit = (addr[31:24] == CLUSTER_BASE);
    window_hit  = (addr[23:20] >= PERIPH_WIN_LO) && (addr[23:20] <= PERIPH_WIN_HI);
    return cluster_hit && window_hit;
  endfunction

endpackage

//--- filelist.f
common/periph_xbar_pkg.sv
src/periph_req_demux.sv
src/periph_rr_arbiter.sv
src/periph_resp_router.sv
src/periph_xbar.sv
tb/tb_clk_gen.sv
tb/periph_xbar_checker.sv
tb/periph_xbar_asserts.sv
tb/tb_periph_xbar.sv

//--- src/periph_req_demux.sv
`timescale 1ns/1ps

module periph_req_demux
  import periph_xbar_pkg::*;
#(
  parameter int unsigned NB_SLAVES = 4
) (
  input  logic                 req_i,
  input  addr_t                addr_i,
  output logic                 gnt_o,
  output logic [NB_SLAVES-1:0] port_req_o,
  input  logic [NB_SLAVES-1:0] port_gnt_i
);

  localparam int unsigned IDX_W = (NB_SLAVES > 1) ? $clog2(NB_SLAVES) : 1;

  // External peripherals always sit on the top port
  localparam logic [IDX_W-1:0] EXT_PORT = IDX_W'(NB_SLAVES - 1);

  logic [IDX_W-1:0] port_sel;

  // Fixed address decode
  always_comb begin
    if (in_periph_window(addr_i)) begin
      port_sel = addr_i[ROUTING_LSB +: IDX_W];
    end else begin
      port_sel = EXT_PORT;
    end
  end

  // Only the decoded port sees the request
  always_comb begin
    port_req_o           = '0;
    port_req_o[port_sel] = req_i;
  end

  // Grant comes back from the decoded port only
  assign gnt_o = port_gnt_i[port_sel];

endmodule

//--- src/periph_resp_router.sv
`timescale 1ns/1ps

module periph_resp_router
  import periph_xbar_pkg::*;
#(
  parameter int unsigned NB_MASTERS = 4,
  parameter int unsigned NB_SLAVES  = 4,
  parameter int unsigned MASTER_IDX = 0
) (
  input  logic [NB_SLAVES-1:0]                 slv_r_valid_i,
  input  data_t [NB_SLAVES-1:0]                slv_r_rdata_i,
  input  logic [NB_SLAVES-1:0]                 slv_r_opc_i,
  input  logic [NB_SLAVES-1:0][NB_MASTERS-1:0] slv_r_id_i,
  output logic                                 r_valid_o,
  output data_t                                r_rdata_o,
  output logic                                 r_opc_o
);

  logic [NB_SLAVES-1:0] match;

  // A port answers this requester when its id carries our bit
  always_comb begin
    for (int s = 0; s < NB_SLAVES; s++) begin
      match[s] = slv_r_valid_i[s] & slv_r_id_i[s][MASTER_IDX];
    end
  end

  // Walk down so the lowest matching port is the last one written
  always_comb begin
    r_valid_o = 1'b0;
    r_rdata_o = '0;
    r_opc_o   = 1'b0;
    for (int s = NB_SLAVES - 1; s >= 0; s--) begin
      if (match[s]) begin
        r_valid_o = 1'b1;
        r_rdata_o = slv_r_rdata_i[s];
        r_opc_o   = slv_r_opc_i[s];
      end
    end
  end

endmodule

//--- src/periph_rr_arbiter.sv
`timescale 1ns/1ps

module periph_rr_arbiter
  import periph_xbar_pkg::*;
#(
  parameter int unsigned NB_MASTERS = 4
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic [NB_MASTERS-1:0]   req_i,
  output logic [NB_MASTERS-1:0]   gnt_o,
  input  addr_t [NB_MASTERS-1:0]  addr_i,
  input  logic [NB_MASTERS-1:0]   wen_i,
  input  data_t [NB_MASTERS-1:0]  wdata_i,
  input  be_t [NB_MASTERS-1:0]    be_i,
  input  atop_t [NB_MASTERS-1:0]  atop_i,
  output logic                    slv_req_o,
  output addr_t                   slv_addr_o,
  output logic                    slv_wen_o,
  output data_t                   slv_wdata_o,
  output be_t                     slv_be_o,
  output atop_t                   slv_atop_o,
  output logic [NB_MASTERS-1:0]   slv_id_o,
  input  logic                    slv_gnt_i
);

  localparam int unsigned MIDX_W = (NB_MASTERS > 1) ? $clog2(NB_MASTERS) : 1;

  logic [MIDX_W-1:0] rr_ptr_q;
  logic [MIDX_W-1:0] win_idx;
  logic              win_found;
  logic              xfer_done;

  // First requester at or after the pointer, wrapping around
  always_comb begin
    int unsigned cand;
    win_idx   = '0;
    win_found = 1'b0;
    for (int unsigned i = 0; i < NB_MASTERS; i++) begin
      cand = int'(rr_ptr_q) + i;
      if (cand >= NB_MASTERS) begin
        cand = cand - NB_MASTERS;
      end
      if (!win_found && req_i[cand]) begin
        win_found = 1'b1;
        win_idx   = MIDX_W'(cand);
      end
    end
  end

  // Port side: request and winner payload
  assign slv_req_o   = win_found;
  assign slv_addr_o  = addr_i[win_idx];
  assign slv_wen_o   = wen_i[win_idx];
  assign slv_wdata_o = wdata_i[win_idx];
  assign slv_be_o    = be_i[win_idx];
  assign slv_atop_o  = atop_i[win_idx];

  always_comb begin
    slv_id_o          = '0;
    slv_id_o[win_idx] = win_found;
  end

  // Winner is granted only while the peripheral accepts
  assign gnt_o     = slv_id_o & {NB_MASTERS{slv_gnt_i}};
  assign xfer_done = slv_req_o & slv_gnt_i;

  // Priority moves just past the last served master
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q <= '0;
    end else if (xfer_done) begin
      if (win_idx == MIDX_W'(NB_MASTERS - 1)) begin
        rr_ptr_q <= '0;
      end else begin
        rr_ptr_q <= win_idx + 1'b1;
      end
    end
  end

endmodule

//--- src/periph_xbar.sv
`timescale 1ns/1ps

module periph_xbar
  import periph_xbar_pkg::*;
#(
  parameter int unsigned NB_MASTERS = 4,
  parameter int unsigned NB_SLAVES  = 4
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  // Requester side
  input  logic [NB_MASTERS-1:0]                mst_req_i,
  input  addr_t [NB_MASTERS-1:0]               mst_addr_i,
  input  logic [NB_MASTERS-1:0]                mst_wen_i,
  input  data_t [NB_MASTERS-1:0]               mst_wdata_i,
  input  be_t [NB_MASTERS-1:0]                 mst_be_i,
  input  atop_t [NB_MASTERS-1:0]               mst_atop_i,
  output logic [NB_MASTERS-1:0]                mst_gnt_o,
  output logic [NB_MASTERS-1:0]                mst_r_valid_o,
  output data_t [NB_MASTERS-1:0]               mst_r_rdata_o,
  output logic [NB_MASTERS-1:0]                mst_r_opc_o,
  // Peripheral side
  output logic [NB_SLAVES-1:0]                 slv_req_o,
  output addr_t [NB_SLAVES-1:0]                slv_addr_o,
  output logic [NB_SLAVES-1:0]                 slv_wen_o,
  output data_t [NB_SLAVES-1:0]                slv_wdata_o,
  output be_t [NB_SLAVES-1:0]                  slv_be_o,
  output atop_t [NB_SLAVES-1:0]                slv_atop_o,
  output logic [NB_SLAVES-1:0][NB_MASTERS-1:0] slv_id_o,
  input  logic [NB_SLAVES-1:0]                 slv_gnt_i,
  input  logic [NB_SLAVES-1:0]                 slv_r_valid_i,
  input  data_t [NB_SLAVES-1:0]                slv_r_rdata_i,
  input  logic [NB_SLAVES-1:0]                 slv_r_opc_i,
  input  logic [NB_SLAVES-1:0][NB_MASTERS-1:0] slv_r_id_i
);

  // Request and grant matrices, indexed by requester first
  logic [NB_MASTERS-1:0][NB_SLAVES-1:0] mst_port_req;
  logic [NB_MASTERS-1:0][NB_SLAVES-1:0] mst_port_gnt;

  // Same matrices seen from the ports
  logic [NB_SLAVES-1:0][NB_MASTERS-1:0] port_mst_req;
  logic [NB_SLAVES-1:0][NB_MASTERS-1:0] port_mst_gnt;

  for (genvar m = 0; m < NB_MASTERS; m++) begin : gen_transpose_m
    for (genvar s = 0; s < NB_SLAVES; s++) begin : gen_transpose_s
      assign port_mst_req[s][m] = mst_port_req[m][s];
      assign mst_port_gnt[m][s] = port_mst_gnt[s][m];
    end
  end

  // Address decode, one per requester
  for (genvar m = 0; m < NB_MASTERS; m++) begin : gen_demux
    periph_req_demux #(
      .NB_SLAVES (NB_SLAVES)
    ) i_req_demux (
      .req_i      (mst_req_i[m]),
      .addr_i     (mst_addr_i[m]),
      .gnt_o      (mst_gnt_o[m]),
      .port_req_o (mst_port_req[m]),
      .port_gnt_i (mst_port_gnt[m])
    );
  end

  // Round-robin arbitration, one per peripheral port
  for (genvar s = 0; s < NB_SLAVES; s++) begin : gen_arb
    periph_rr_arbiter #(
      .NB_MASTERS (NB_MASTERS)
    ) i_rr_arbiter (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .req_i       (port_mst_req[s]),
      .gnt_o       (port_mst_gnt[s]),
      .addr_i      (mst_addr_i),
      .wen_i       (mst_wen_i),
      .wdata_i     (mst_wdata_i),
      .be_i        (mst_be_i),
      .atop_i      (mst_atop_i),
      .slv_req_o   (slv_req_o[s]),
      .slv_addr_o  (slv_addr_o[s]),
      .slv_wen_o   (slv_wen_o[s]),
      .slv_wdata_o (slv_wdata_o[s]),
      .slv_be_o    (slv_be_o[s]),
      .slv_atop_o  (slv_atop_o[s]),
      .slv_id_o    (slv_id_o[s]),
      .slv_gnt_i   (slv_gnt_i[s])
    );
  end

  // Responses steered back by the one-hot id
  for (genvar m = 0; m < NB_MASTERS; m++) begin : gen_resp
    periph_resp_router #(
      .NB_MASTERS (NB_MASTERS),
      .NB_SLAVES  (NB_SLAVES),
      .MASTER_IDX (m)
    ) i_resp_router (
      .slv_r_valid_i (slv_r_valid_i),
      .slv_r_rdata_i (slv_r_rdata_i),
      .slv_r_opc_i   (slv_r_opc_i),
      .slv_r_id_i    (slv_r_id_i),
      .r_valid_o     (mst_r_valid_o[m]),
      .r_rdata_o     (mst_r_rdata_o[m]),
      .r_opc_o       (mst_r_opc_o[m])
    );
  end

endmodule

//--- tb/periph_xbar_asserts.sv
`timescale 1ns/1ps

module periph_xbar_asserts #(
  parameter int unsigned NB_MASTERS = 4,
  parameter int unsigned NB_SLAVES  = 4
) (
  input logic                                 clk_i,
  input logic                                 arst_n_i,
  input logic [NB_MASTERS-1:0]                mst_req_i,
  input logic [NB_MASTERS-1:0]                mst_gnt_i,
  input logic [NB_SLAVES-1:0]                 slv_req_i,
  input logic [NB_SLAVES-1:0]                 slv_gnt_i,
  input logic [NB_SLAVES-1:0][NB_MASTERS-1:0] slv_id_i,
  input logic [NB_SLAVES-1:0][NB_MASTERS-1:0] port_req_i
);

  int unsigned fail_cnt = 0;

  for (genvar m = 0; m < NB_MASTERS; m++) begin : gen_mst
    a_gnt_has_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mst_gnt_i[m] |-> mst_req_i[m])
      else begin
        fail_cnt++;
        $error("Requester %0d granted without a pending request", m);
      end
  end

  for (genvar s = 0; s < NB_SLAVES; s++) begin : gen_port
    a_id_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      slv_req_i[s] |-> $onehot(slv_id_i[s]))
      else begin
        fail_cnt++;
        $error("Port %0d id is not one-hot while requesting", s);
      end

    // Same waiting requesters under a stall means the same winner
    a_stall_keeps_id: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      slv_req_i[s] && !slv_gnt_i[s] |=> slv_req_i[s] &&
        ((port_req_i[s] != $past(port_req_i[s])) || $stable(slv_id_i[s])))
      else begin
        fail_cnt++;
        $error("Port %0d changed its id or dropped its request under back-pressure", s);
      end
  end

endmodule

//--- tb/periph_xbar_checker.sv
`timescale 1ns/1ps

module periph_xbar_checker
  import periph_xbar_pkg::*;
#(
  parameter int unsigned NB_MASTERS = 4,
  parameter int unsigned NB_SLAVES  = 4,
  parameter int unsigned N_XFERS    = 200
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 done_i,
  input  logic [NB_MASTERS-1:0]                mst_req_i,
  input  addr_t [NB_MASTERS-1:0]               mst_addr_i,
  input  logic [NB_MASTERS-1:0]                mst_wen_i,
  input  data_t [NB_MASTERS-1:0]               mst_wdata_i,
  input  be_t [NB_MASTERS-1:0]                 mst_be_i,
  input  atop_t [NB_MASTERS-1:0]               mst_atop_i,
  input  logic [NB_MASTERS-1:0]                mst_gnt_i,
  input  logic [NB_MASTERS-1:0]                mst_r_valid_i,
  input  data_t [NB_MASTERS-1:0]               mst_r_rdata_i,
  input  logic [NB_MASTERS-1:0]                mst_r_opc_i,
  input  logic [NB_SLAVES-1:0]                 slv_req_i,
  input  addr_t [NB_SLAVES-1:0]                slv_addr_i,
  input  logic [NB_SLAVES-1:0]                 slv_wen_i,
  input  data_t [NB_SLAVES-1:0]                slv_wdata_i,
  input  be_t [NB_SLAVES-1:0]                  slv_be_i,
  input  atop_t [NB_SLAVES-1:0]                slv_atop_i,
  input  logic [NB_SLAVES-1:0][NB_MASTERS-1:0] slv_id_i,
  input  logic [NB_SLAVES-1:0]                 slv_gnt_i,
  input  logic [NB_SLAVES-1:0]                 slv_r_valid_i,
  input  data_t [NB_SLAVES-1:0]                slv_r_rdata_i,
  input  logic [NB_SLAVES-1:0]                 slv_r_opc_i,
  input  logic [NB_SLAVES-1:0][NB_MASTERS-1:0] slv_r_id_i,
  output int unsigned                          err_cnt_o,
  output int unsigned                          chk_cnt_o
);

  localparam int unsigned IDX_W = (NB_SLAVES > 1) ? $clog2(NB_SLAVES) : 1;

  int unsigned           rr_ptr [NB_SLAVES];
  int                    winner [NB_SLAVES];
  int unsigned           dst_port [NB_MASTERS];
  int unsigned           resp_cnt [NB_MASTERS];
  logic [NB_MASTERS-1:0] port_reqs;
  logic                  exp_gnt;
  int unsigned           n_gnt;
  logic                  exp_valid;
  data_t                 exp_rdata;
  logic                  exp_opc;
  logic                  final_done = 1'b0;

  initial begin
    err_cnt_o = 0;
    chk_cnt_o = 0;
  end

  // Port a requester should reach, straight from the address map
  function automatic int unsigned expected_port(addr_t addr);
    if ((addr[31:24] == CLUSTER_BASE) && (addr[23:20] >= PERIPH_WIN_LO) &&
        (addr[23:20] <= PERIPH_WIN_HI)) begin
      return int'(addr[ROUTING_LSB +: IDX_W]);
    end
    return NB_SLAVES - 1;
  endfunction

  // Round-robin choice, -1 when nobody asks
  function automatic int pick_winner(logic [NB_MASTERS-1:0] reqs, int unsigned ptr);
    int unsigned idx;
    for (int unsigned i = 0; i < NB_MASTERS; i++) begin
      idx = (ptr + i) % NB_MASTERS;
      if (reqs[idx]) begin
        return int'(idx);
      end
    end
    return -1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    chk_cnt_o++;
    if (actual !== expected) begin
      err_cnt_o++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  always @(posedge clk_i) begin
    if (!arst_n_i || (mst_req_i == '0)) begin
      check_value("slv_req_o (idle)", '0, 32'(slv_req_i));
      check_value("mst_gnt_o (idle)", '0, 32'(mst_gnt_i));
    end
    if (!arst_n_i) begin
      for (int unsigned s = 0; s < NB_SLAVES; s++) begin
        rr_ptr[s] = 0;
      end
      for (int unsigned m = 0; m < NB_MASTERS; m++) begin
        resp_cnt[m] = 0;
      end
    end else begin
      for (int unsigned m = 0; m < NB_MASTERS; m++) begin
        dst_port[m] = expected_port(mst_addr_i[m]);
      end

      // Port side: winner, id and forwarded payload
      for (int unsigned s = 0; s < NB_SLAVES; s++) begin
        port_reqs = '0;
        for (int unsigned m = 0; m < NB_MASTERS; m++) begin
          port_reqs[m] = mst_req_i[m] && (dst_port[m] == s);
        end
        winner[s] = pick_winner(port_reqs, rr_ptr[s]);
        check_value($sformatf("slv_req_o[%0d]", s), 32'(winner[s] >= 0), 32'(slv_req_i[s]));
        if (winner[s] >= 0) begin
          check_value($sformatf("slv_id_o[%0d]", s), 32'(1) << winner[s], 32'(slv_id_i[s]));
          check_value($sformatf("slv_addr_o[%0d]", s), mst_addr_i[winner[s]], slv_addr_i[s]);
          check_value($sformatf("slv_wdata_o[%0d]", s), mst_wdata_i[winner[s]],
                      slv_wdata_i[s]);
          check_value($sformatf("slv_wen_o[%0d]", s), 32'(mst_wen_i[winner[s]]),
                      32'(slv_wen_i[s]));
          check_value($sformatf("slv_be_o[%0d]", s), 32'(mst_be_i[winner[s]]),
                      32'(slv_be_i[s]));
          check_value($sformatf("slv_atop_o[%0d]", s), 32'(mst_atop_i[winner[s]]),
                      32'(slv_atop_i[s]));
          if (slv_gnt_i[s]) begin
            rr_ptr[s] = (int'(winner[s]) + 1) % NB_MASTERS;
          end
        end
      end

      // Requester side: grant legality and responses
      for (int unsigned m = 0; m < NB_MASTERS; m++) begin
        exp_gnt = mst_req_i[m] && (winner[dst_port[m]] == int'(m)) && slv_gnt_i[dst_port[m]];
        check_value($sformatf("mst_gnt_o[%0d]", m), 32'(exp_gnt), 32'(mst_gnt_i[m]));
        exp_valid = 1'b0;
        exp_rdata = '0;
        exp_opc   = 1'b0;
        for (int unsigned s = 0; s < NB_SLAVES; s++) begin
          if (!exp_valid && slv_r_valid_i[s] && slv_r_id_i[s][m]) begin
            exp_valid = 1'b1;
            exp_rdata = slv_r_rdata_i[s];
            exp_opc   = slv_r_opc_i[s];
          end
        end
        check_value($sformatf("mst_r_valid_o[%0d]", m), 32'(exp_valid), 32'(mst_r_valid_i[m]));
        check_value($sformatf("mst_r_rdata_o[%0d]", m), exp_rdata, mst_r_rdata_i[m]);
        check_value($sformatf("mst_r_opc_o[%0d]", m), 32'(exp_opc), 32'(mst_r_opc_i[m]));
        if (mst_r_valid_i[m]) begin
          resp_cnt[m]++;
        end
      end

      for (int unsigned s = 0; s < NB_SLAVES; s++) begin
        n_gnt = 0;
        for (int unsigned m = 0; m < NB_MASTERS; m++) begin
          if (mst_gnt_i[m] && (dst_port[m] == s)) begin
            n_gnt++;
          end
        end
        if (n_gnt > 1) begin
          err_cnt_o++;
          $display("Error at %0t: %0d requesters granted on port %0d in one cycle",
                   $time, n_gnt, s);
        end
      end

      if (done_i && !final_done) begin
        final_done = 1'b1;
        for (int unsigned m = 0; m < NB_MASTERS; m++) begin
          if (resp_cnt[m] != N_XFERS) begin
            err_cnt_o++;
            $display("Error: requester %0d received %0d responses instead of %0d",
                     m, resp_cnt[m], N_XFERS);
          end
        end
      end
    end
  end

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned HALF_PERIOD = 20,
  parameter int unsigned RST_CYCLES  = 3
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD) clk_o = ~clk_o;
    end
  end

  // Reset released on a rising edge after RST_CYCLES cycles
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

//--- tb/tb_periph_xbar.sv
`timescale 1ns/1ps

module tb_periph_xbar
  import periph_xbar_pkg::*;
();

  localparam int unsigned NB_MASTERS     = 4;
  localparam int unsigned NB_SLAVES      = 4;
  localparam int unsigned N_XFERS        = 200;
  localparam int unsigned TIMEOUT_CYCLES = N_XFERS * NB_MASTERS * 10;

  typedef enum logic [1:0] {MST_WAIT, MST_REQ, MST_RESP, MST_DONE} mst_state_e;

  logic clk_i;
  logic arst_n_i;

  logic [NB_MASTERS-1:0]                mst_req_i = '0;
  addr_t [NB_MASTERS-1:0]               mst_addr_i = '0;
  logic [NB_MASTERS-1:0]                mst_wen_i = '0;
  data_t [NB_MASTERS-1:0]               mst_wdata_i = '0;
  be_t [NB_MASTERS-1:0]                 mst_be_i = '0;
  atop_t [NB_MASTERS-1:0]               mst_atop_i = '0;
  logic [NB_MASTERS-1:0]                mst_gnt_o;
  logic [NB_MASTERS-1:0]                mst_r_valid_o;
  data_t [NB_MASTERS-1:0]               mst_r_rdata_o;
  logic [NB_MASTERS-1:0]                mst_r_opc_o;
  logic [NB_SLAVES-1:0]                 slv_req_o;
  addr_t [NB_SLAVES-1:0]                slv_addr_o;
  logic [NB_SLAVES-1:0]                 slv_wen_o;
  data_t [NB_SLAVES-1:0]                slv_wdata_o;
  be_t [NB_SLAVES-1:0]                  slv_be_o;
  atop_t [NB_SLAVES-1:0]                slv_atop_o;
  logic [NB_SLAVES-1:0][NB_MASTERS-1:0] slv_id_o;
  logic [NB_SLAVES-1:0]                 slv_gnt_i = '0;
  logic [NB_SLAVES-1:0]                 slv_r_valid_i = '0;
  data_t [NB_SLAVES-1:0]                slv_r_rdata_i = '0;
  logic [NB_SLAVES-1:0]                 slv_r_opc_i = '0;
  logic [NB_SLAVES-1:0][NB_MASTERS-1:0] slv_r_id_i = '0;

  mst_state_e  mst_state [NB_MASTERS];
  int unsigned wait_cnt [NB_MASTERS];
  int unsigned xfer_cnt [NB_MASTERS];
  int unsigned n_done;
  logic        all_done = 1'b0;
  logic        done = 1'b0;
  int unsigned err_cnt;
  int unsigned chk_cnt;
  int unsigned total_err;
  int          seed = 81;

  tb_clk_gen i_clk_gen (
    .clk_o    (clk_i),
    .arst_n_o (arst_n_i)
  );

  periph_xbar #(
    .NB_MASTERS (NB_MASTERS),
    .NB_SLAVES  (NB_SLAVES)
  ) i_dut (.*);

  periph_xbar_checker #(
    .NB_MASTERS (NB_MASTERS),
    .NB_SLAVES  (NB_SLAVES),
    .N_XFERS    (N_XFERS)
  ) i_checker (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .done_i        (done),
    .mst_req_i     (mst_req_i),
    .mst_addr_i    (mst_addr_i),
    .mst_wen_i     (mst_wen_i),
    .mst_wdata_i   (mst_wdata_i),
    .mst_be_i      (mst_be_i),
    .mst_atop_i    (mst_atop_i),
    .mst_gnt_i     (mst_gnt_o),
    .mst_r_valid_i (mst_r_valid_o),
    .mst_r_rdata_i (mst_r_rdata_o),
    .mst_r_opc_i   (mst_r_opc_o),
    .slv_req_i     (slv_req_o),
    .slv_addr_i    (slv_addr_o),
    .slv_wen_i     (slv_wen_o),
    .slv_wdata_i   (slv_wdata_o),
    .slv_be_i      (slv_be_o),
    .slv_atop_i    (slv_atop_o),
    .slv_id_i      (slv_id_o),
    .slv_gnt_i     (slv_gnt_i),
    .slv_r_valid_i (slv_r_valid_i),
    .slv_r_rdata_i (slv_r_rdata_i),
    .slv_r_opc_i   (slv_r_opc_i),
    .slv_r_id_i    (slv_r_id_i),
    .err_cnt_o     (err_cnt),
    .chk_cnt_o     (chk_cnt)
  );

  bind periph_xbar periph_xbar_asserts #(
    .NB_MASTERS (NB_MASTERS),
    .NB_SLAVES  (NB_SLAVES)
  ) i_asserts (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .mst_req_i  (mst_req_i),
    .mst_gnt_i  (mst_gnt_o),
    .slv_req_i  (slv_req_o),
    .slv_gnt_i  (slv_gnt_i),
    .slv_id_i   (slv_id_o),
    .port_req_i (port_mst_req)
  );

  // Half the addresses hit the peripheral window on a random port
  // The others miss it by the cluster byte or by the window nibble
  task automatic issue_request(input int unsigned m);
    addr_t addr;
    addr = addr_t'($random(seed));
    if (($random(seed) & 1) != 0) begin
      addr[31:24] = CLUSTER_BASE;
      addr[23:20] = PERIPH_WIN_LO + 4'($random(seed) & 1);
    end else if (($random(seed) & 1) != 0) begin
      // Window nibble in another cluster
      addr[31:24] = CLUSTER_BASE ^ (8'h01 << ($random(seed) & 7));
      addr[23:20] = PERIPH_WIN_LO + 4'($random(seed) & 1);
    end else begin
      // This cluster with a nibble below or above the window
      addr[31:24] = CLUSTER_BASE;
      if ((addr[23:20] >= PERIPH_WIN_LO) && (addr[23:20] <= PERIPH_WIN_HI)) begin
        addr[23:20] = addr[23:20] + 4'h2;
      end
    end
    mst_req_i[m]   <= 1'b1;
    mst_addr_i[m]  <= addr;
    mst_wen_i[m]   <= 1'($random(seed));
    mst_wdata_i[m] <= data_t'($random(seed));
    mst_be_i[m]    <= be_t'($random(seed));
    mst_atop_i[m]  <= atop_t'($random(seed));
  endtask

  // Requester and peripheral models share one process so the random order is fixed
  always @(posedge clk_i) begin
    if (!arst_n_i) begin
      mst_req_i     <= '0;
      slv_gnt_i     <= '0;
      slv_r_valid_i <= '0;
      for (int unsigned m = 0; m < NB_MASTERS; m++) begin
        mst_state[m] = MST_WAIT;
        wait_cnt[m]  = 0;
        xfer_cnt[m]  = 0;
      end
    end else begin
      for (int unsigned m = 0; m < NB_MASTERS; m++) begin
        case (mst_state[m])
          MST_WAIT: begin
            if (wait_cnt[m] == 0) begin
              issue_request(m);
              mst_state[m] = MST_REQ;
            end else begin
              wait_cnt[m]--;
            end
          end
          MST_REQ: begin
            if (mst_gnt_o[m]) begin
              mst_req_i[m] <= 1'b0;
              mst_state[m] = MST_RESP;
            end
          end
          MST_RESP: begin
            if (mst_r_valid_o[m]) begin
              xfer_cnt[m]++;
              wait_cnt[m] = 32'($random(seed) & 3);
              if (xfer_cnt[m] == N_XFERS) begin
                mst_state[m] = MST_DONE;
              end else begin
                mst_state[m] = MST_WAIT;
              end
            end
          end
          default: begin
          end
        endcase
      end
      // Each peripheral answers exactly one cycle after a transfer
      for (int unsigned s = 0; s < NB_SLAVES; s++) begin
        slv_gnt_i[s]     <= 1'($random(seed));
        slv_r_valid_i[s] <= slv_req_o[s] & slv_gnt_i[s];
        slv_r_id_i[s]    <= slv_id_o[s];
        slv_r_rdata_i[s] <= slv_addr_o[s] ^ slv_wdata_o[s];
        slv_r_opc_i[s]   <= slv_wen_o[s];
      end
    end
    n_done = 0;
    for (int unsigned m = 0; m < NB_MASTERS; m++) begin
      if (mst_state[m] == MST_DONE) begin
        n_done++;
      end
    end
    all_done = (n_done == NB_MASTERS);
  end

  initial begin
    wait (all_done);
    repeat (2) @(posedge clk_i);
    done <= 1'b1;
    repeat (2) @(negedge clk_i);
    total_err = err_cnt + i_dut.i_asserts.fail_cnt;
    $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
             chk_cnt, err_cnt, i_dut.i_asserts.fail_cnt);
    if (total_err == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout: requesters did not finish their %0d transfers within %0d cycles",
             N_XFERS, TIMEOUT_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
